//--- mcr3_game_pkg.sv
package mcr3_game_pkg;

	// ====================
	// Game selection
	// ====================

	typedef enum logic [2:0] {
		GAME_SARGE    = 3'd1,
		GAME_POWERDRV = 3'd2,
		GAME_MAXRPM   = 3'd3,
		GAME_DDERBY   = 3'd4
	} game_t;

	// Wishbone register map of the CPU ports
	typedef enum logic [2:0] {
		PORT_IN0  = 3'd0,
		PORT_IN1  = 3'd1,
		PORT_IN2  = 3'd2,
		PORT_IN3  = 3'd3,
		PORT_IN4  = 3'd4,
		PORT_OUT5 = 3'd5,
		PORT_OUT6 = 3'd6
	} port_addr_t;

	// ====================
	// Max RPM gearbox
	// ====================

	localparam int RPM_GEAR_MAX = 4;

	// Shifter pattern the game expects for gears 0 to 4
	localparam logic [3:0] RPM_GEAR_CODES [0:RPM_GEAR_MAX] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};

	// Demolition Derby wheel bank select, output port 6
	localparam int DDERBY_SEL_SET_BIT = 6;
	localparam int DDERBY_SEL_CLR_BIT = 7;

endpackage

//--- cabinet_io_pkg.sv
package cabinet_io_pkg;

	// ====================
	// Cabinet counts
	// ====================

	localparam int NUM_PLAYERS = 4;
	localparam int NUM_WHEELS  = 4;

	// Spinner position width, wraps at 64
	localparam int WHEEL_W = 6;

	// CPU data port width
	localparam int PORT_W = 8;

	// DIP switch bank
	localparam int DIP_W = 4;

	// ====================
	// Player controls
	// ====================

	// Decoded joystick and buttons, all active high
	typedef struct packed {
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} stick_t;

endpackage

//--- cabinet_ctrl_if.sv
`timescale 1ns/1ps

interface cabinet_ctrl_if;
	import mcr3_game_pkg::*;
	import cabinet_io_pkg::*;

	game_t                  game;
	logic                   service;
	logic [DIP_W-1:0]       dip;
	logic [NUM_PLAYERS-1:0] coin;
	logic [NUM_PLAYERS-1:0] start;
	stick_t                 stick [NUM_PLAYERS];

	// Power Drive gear toggles and Max RPM gear numbers
	logic [2:0]             pd_gear;
	logic [2:0]             rpm_gear [2];

	// Sarge treads, four up/down pairs and two fire pairs
	logic [3:0]             tank_up;
	logic [3:0]             tank_down;
	logic [1:0]             tank_fire_a;
	logic [1:0]             tank_fire_b;

	modport decoder (output game, service, dip, coin, start, stick, pd_gear, rpm_gear,
		tank_up, tank_down, tank_fire_a, tank_fire_b);

	modport port_bank (input game, service, dip, coin, start, stick, pd_gear, rpm_gear,
		tank_up, tank_down, tank_fire_a, tank_fire_b);

endinterface

//--- control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  mcr3_game_pkg::game_t                   game,
	input  logic                                   onestick,
	input  logic                                   service,
	input  logic [cabinet_io_pkg::DIP_W-1:0]       dip,
	input  logic [cabinet_io_pkg::NUM_PLAYERS-1:0] coin,
	input  logic [cabinet_io_pkg::NUM_PLAYERS-1:0] start,
	input  cabinet_io_pkg::stick_t                 stick [cabinet_io_pkg::NUM_PLAYERS],
	input  logic                                   vsync,
	cabinet_ctrl_if.decoder                        ctrl,
	output logic [cabinet_io_pkg::NUM_WHEELS-1:0]  spin_left,
	output logic [cabinet_io_pkg::NUM_WHEELS-1:0]  spin_right,
	output logic                                   vs_tick
);
	import mcr3_game_pkg::*;
	import cabinet_io_pkg::*;

	// First synchronizer stage
	game_t                  game_s1;
	logic                   onestick_s1;
	logic                   service_s1;
	logic [DIP_W-1:0]       dip_s1;
	logic [NUM_PLAYERS-1:0] coin_s1;
	logic [NUM_PLAYERS-1:0] start_s1;
	stick_t                 stick_s1 [NUM_PLAYERS];
	logic                   vs_s1;
	logic                   vs_s2;
	logic                   vs_s3;

	// Tread mapping ahead of the second stage
	logic [3:0]             tank_up_c;
	logic [3:0]             tank_down_c;
	logic [1:0]             tank_fire_a_c;
	logic [1:0]             tank_fire_b_c;

	// Edge detect history
	logic [2:0]             pd_prev;
	logic [1:0]             gear_up_prev;
	logic [1:0]             gear_dn_prev;

	// ====================
	// Synchronizers
	// ====================

	always_ff @(posedge clk_sys) begin
		game_s1     <= game;
		onestick_s1 <= onestick;
		service_s1  <= service;
		dip_s1      <= dip;
		coin_s1     <= coin;
		start_s1    <= start;
		stick_s1    <= stick;
		vs_s1       <= vsync;
	end

	// Second stage is the interface itself
	always_ff @(posedge clk_sys) begin
		ctrl.game        <= game_s1;
		ctrl.service     <= service_s1;
		ctrl.dip         <= dip_s1;
		ctrl.coin        <= coin_s1;
		ctrl.start       <= start_s1;
		ctrl.stick       <= stick_s1;
		ctrl.tank_up     <= tank_up_c;
		ctrl.tank_down   <= tank_down_c;
		ctrl.tank_fire_a <= tank_fire_a_c;
		ctrl.tank_fire_b <= tank_fire_b_c;
		vs_s2            <= vs_s1;
	end

	// ====================
	// Sarge tank sticks
	// ====================

	always_comb begin
		if (onestick_s1) begin
			// One stick per tank, diagonals steer the treads
			for (int p = 0; p < 2; p++) begin
				tank_up_c[2*p]     = (stick_s1[p].up & ~stick_s1[p].left) |
					(stick_s1[p].right & ~stick_s1[p].down);
				tank_up_c[2*p+1]   = (stick_s1[p].up & ~stick_s1[p].right) |
					(stick_s1[p].left & ~stick_s1[p].down);
				tank_down_c[2*p]   = (stick_s1[p].down & ~stick_s1[p].right) |
					(stick_s1[p].left & ~stick_s1[p].up);
				tank_down_c[2*p+1] = (stick_s1[p].down & ~stick_s1[p].left) |
					(stick_s1[p].right & ~stick_s1[p].up);
				tank_fire_a_c[p]   = stick_s1[p].fire_a;
				tank_fire_b_c[p]   = stick_s1[p].fire_b;
			end
		end else begin
			for (int i = 0; i < NUM_PLAYERS; i++) begin
				tank_up_c[i]   = stick_s1[i].up;
				tank_down_c[i] = stick_s1[i].down;
			end
			tank_fire_a_c[0] = stick_s1[0].fire_a | stick_s1[1].fire_a;
			tank_fire_b_c[0] = stick_s1[0].fire_b | stick_s1[1].fire_b;
			tank_fire_a_c[1] = stick_s1[2].fire_a | stick_s1[3].fire_a;
			tank_fire_b_c[1] = stick_s1[2].fire_b | stick_s1[3].fire_b;
		end
	end

	// ====================
	// Gears and vsync tick
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pd_prev       <= '0;
			gear_up_prev  <= '0;
			gear_dn_prev  <= '0;
			ctrl.pd_gear  <= '0;
			ctrl.rpm_gear <= '{3'd0, 3'd0};
			vs_s3         <= 1'b0;
			vs_tick       <= 1'b0;
		end else begin
			// Power Drive, fire_d of players 1 to 3 flips the gear
			for (int i = 0; i < 3; i++) begin
				if (ctrl.stick[i].fire_d && !pd_prev[i])
					ctrl.pd_gear[i] <= ~ctrl.pd_gear[i];
				pd_prev[i] <= ctrl.stick[i].fire_d;
			end

			// Max RPM, start wins over the shift buttons
			for (int p = 0; p < 2; p++) begin
				if (ctrl.start[p])
					ctrl.rpm_gear[p] <= 3'd0;
				else if (ctrl.stick[p].fire_a && !gear_up_prev[p] &&
						ctrl.rpm_gear[p] != 3'(RPM_GEAR_MAX))
					ctrl.rpm_gear[p] <= ctrl.rpm_gear[p] + 3'd1;
				else if (ctrl.stick[p].fire_b && !gear_dn_prev[p] && ctrl.rpm_gear[p] != 3'd0)
					ctrl.rpm_gear[p] <= ctrl.rpm_gear[p] - 3'd1;
				gear_up_prev[p] <= ctrl.stick[p].fire_a;
				gear_dn_prev[p] <= ctrl.stick[p].fire_b;
			end

			vs_s3   <= vs_s2;
			vs_tick <= vs_s2 & ~vs_s3;
		end
	end

	// Spinners follow each player's left and right
	always_comb begin
		for (int i = 0; i < NUM_WHEELS; i++) begin
			spin_left[i]  = ctrl.stick[i].left;
			spin_right[i] = ctrl.stick[i].right;
		end
	end

endmodule

//--- wheel_spinner.sv
`timescale 1ns/1ps

module wheel_spinner (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               vs_tick,
	input  logic                               left,
	input  logic                               right,
	output logic [cabinet_io_pkg::WHEEL_W-1:0] position
);
	import cabinet_io_pkg::*;

	// Direction requested for this frame
	typedef enum logic [1:0] {
		SPIN_HOLD  = 2'b00,
		SPIN_RIGHT = 2'b01,
		SPIN_LEFT  = 2'b10,
		SPIN_BOTH  = 2'b11
	} spin_dir_t;

	spin_dir_t dir;

	assign dir = spin_dir_t'({left, right});

	// ====================
	// Position counter
	// ====================

	// One step per frame with free wraparound
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			position <= '0;
		end else if (vs_tick) begin
			case (dir)
				SPIN_RIGHT: position <= position + WHEEL_W'(1);
				SPIN_LEFT:  position <= position - WHEEL_W'(1);
				// Both or neither held leaves the wheel still
				default:    position <= position;
			endcase
		end
	end

endmodule

//--- io_port_bank.sv
`timescale 1ns/1ps

module io_port_bank (
	input  logic                               clk_sys,
	input  logic                               reset,
	cabinet_ctrl_if.port_bank                  ctrl,
	input  logic [cabinet_io_pkg::WHEEL_W-1:0] wheel [cabinet_io_pkg::NUM_WHEELS],
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic                               wb_we,
	input  logic [2:0]                         wb_adr,
	input  logic [cabinet_io_pkg::PORT_W-1:0]  wb_dat_w,
	output logic [cabinet_io_pkg::PORT_W-1:0]  wb_dat_r,
	output logic                               wb_ack
);
	import mcr3_game_pkg::*;
	import cabinet_io_pkg::*;

	typedef enum logic {
		IDLE,
		ACK
	} wb_state_t;

	wb_state_t         state;
	port_addr_t        addr;
	logic              req;

	logic [PORT_W-1:0] out5;
	logic [PORT_W-1:0] out6;
	logic              dderby_sel;

	// Input ports, active high before the final inversion
	logic [PORT_W-1:0] port_c [5];
	logic [PORT_W-1:0] in_port [5];
	logic [PORT_W-1:0] rd_data;
	logic [WHEEL_W-1:0] wheel_a;
	logic [WHEEL_W-1:0] wheel_b;

	assign addr   = port_addr_t'(wb_adr);
	assign req    = (state == IDLE) && wb_cyc && wb_stb;
	assign wb_ack = (state == ACK);

	// ====================
	// Input port forming
	// ====================

	assign wheel_a = dderby_sel ? wheel[2] : wheel[0];
	assign wheel_b = dderby_sel ? wheel[3] : wheel[1];

	always_comb begin
		port_c[0] = {2'b00, ctrl.service, 1'b0, ctrl.start[1:0], ctrl.coin[1:0]};
		port_c[1] = '0;
		port_c[2] = '0;
		port_c[3] = {4'b0000, ctrl.dip};
		port_c[4] = '0;

		case (ctrl.game)
			GAME_SARGE: begin
				port_c[1] = {{2{ctrl.tank_fire_b[0]}}, {2{ctrl.tank_fire_a[0]}},
					ctrl.tank_down[1], ctrl.tank_up[1], ctrl.tank_down[0], ctrl.tank_up[0]};
				port_c[2] = {{2{ctrl.tank_fire_b[1]}}, {2{ctrl.tank_fire_a[1]}},
					ctrl.tank_down[2], ctrl.tank_up[2], ctrl.tank_down[3], ctrl.tank_up[3]};
			end
			GAME_POWERDRV: begin
				port_c[1] = {ctrl.stick[1].fire_b, ctrl.stick[1].fire_a, ctrl.pd_gear[1],
					ctrl.stick[1].fire_c, ctrl.stick[0].fire_b, ctrl.stick[0].fire_a,
					ctrl.pd_gear[0], ctrl.stick[0].fire_c};
				port_c[2] = {4'b0000, ctrl.stick[2].fire_b, ctrl.stick[2].fire_a,
					ctrl.pd_gear[2], ctrl.stick[2].fire_c};
			end
			GAME_MAXRPM: begin
				// No pedal or steering ADC, port 1 stays idle
				port_c[2] = {RPM_GEAR_CODES[ctrl.rpm_gear[0]], RPM_GEAR_CODES[ctrl.rpm_gear[1]]};
			end
			GAME_DDERBY: begin
				port_c[1] = {wheel_a, ctrl.stick[0].fire_b, ctrl.stick[0].fire_a};
				port_c[2] = {wheel_b, ctrl.stick[1].fire_b, ctrl.stick[1].fire_a};
				port_c[4] = {ctrl.stick[3].fire_b, ctrl.stick[3].fire_a, ctrl.stick[2].fire_b,
					ctrl.stick[2].fire_a, ctrl.start[3:2], ctrl.coin[3:2]};
			end
			default: ;
		endcase
	end

	// Active low on the CPU side
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < 5; i++)
			in_port[i] <= ~port_c[i];
	end

	// ====================
	// Wishbone slave
	// ====================

	always_comb begin
		case (addr)
			PORT_IN0:  rd_data = in_port[0];
			PORT_IN1:  rd_data = in_port[1];
			PORT_IN2:  rd_data = in_port[2];
			PORT_IN3:  rd_data = in_port[3];
			PORT_IN4:  rd_data = in_port[4];
			PORT_OUT5: rd_data = out5;
			PORT_OUT6: rd_data = out6;
			default:   rd_data = '1;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= IDLE;
			out5       <= '0;
			out6       <= '0;
			dderby_sel <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state <= ACK;
						if (wb_we && addr == PORT_OUT5)
							out5 <= wb_dat_w;
						if (wb_we && addr == PORT_OUT6) begin
							out6 <= wb_dat_w;
							// Clear wins when both bits are set
							if (wb_dat_w[DDERBY_SEL_CLR_BIT])
								dderby_sel <= 1'b0;
							else if (wb_dat_w[DDERBY_SEL_SET_BIT])
								dderby_sel <= 1'b1;
						end
					end
				end
				ACK: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Read data held for the ack cycle
	always_ff @(posedge clk_sys) begin
		if (req)
			wb_dat_r <= rd_data;
	end

endmodule

//--- mcr3_input_top.sv
`timescale 1ns/1ps

module mcr3_input_top (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  mcr3_game_pkg::game_t                   game,
	input  logic                                   onestick,
	input  logic                                   service,
	input  logic [cabinet_io_pkg::DIP_W-1:0]       dip,
	input  logic [cabinet_io_pkg::NUM_PLAYERS-1:0] coin,
	input  logic [cabinet_io_pkg::NUM_PLAYERS-1:0] start,
	input  logic [7:0]                             p1_stick,
	input  logic [7:0]                             p2_stick,
	input  logic [7:0]                             p3_stick,
	input  logic [7:0]                             p4_stick,
	input  logic                                   vsync,
	input  logic                                   wb_cyc,
	input  logic                                   wb_stb,
	input  logic                                   wb_we,
	input  logic [2:0]                             wb_adr,
	input  logic [cabinet_io_pkg::PORT_W-1:0]      wb_dat_w,
	output logic [cabinet_io_pkg::PORT_W-1:0]      wb_dat_r,
	output logic                                   wb_ack
);
	import cabinet_io_pkg::*;

	stick_t             stick [NUM_PLAYERS];
	logic [NUM_WHEELS-1:0] spin_left;
	logic [NUM_WHEELS-1:0] spin_right;
	logic               vs_tick;
	logic [WHEEL_W-1:0] wheel [NUM_WHEELS];

	cabinet_ctrl_if ctrl_if ();

	assign stick[0] = p1_stick;
	assign stick[1] = p2_stick;
	assign stick[2] = p3_stick;
	assign stick[3] = p4_stick;

	control_decoder control_decoder_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.game       (game),
		.onestick   (onestick),
		.service    (service),
		.dip        (dip),
		.coin       (coin),
		.start      (start),
		.stick      (stick),
		.vsync      (vsync),
		.ctrl       (ctrl_if.decoder),
		.spin_left  (spin_left),
		.spin_right (spin_right),
		.vs_tick    (vs_tick)
	);

	// One spinner per Derby steering wheel
	for (genvar i = 0; i < NUM_WHEELS; i++) begin : g_wheel
		wheel_spinner wheel_spinner_inst (
			.clk_sys  (clk_sys),
			.reset    (reset),
			.vs_tick  (vs_tick),
			.left     (spin_left[i]),
			.right    (spin_right[i]),
			.position (wheel[i])
		);
	end

	io_port_bank io_port_bank_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ctrl     (ctrl_if.port_bank),
		.wheel    (wheel),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	// 100 MHz system clock
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Reset held for the first 4 rising edges
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

//--- tb_port_checker.sv
`timescale 1ns/1ps

module tb_port_checker (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       wb_cyc,
	input  logic       wb_we,
	input  logic       wb_ack,
	input  logic [2:0] wb_adr,
	input  logic [7:0] wb_dat_r,
	input  logic [7:0] exp_data,
	output int         error_count,
	output int         read_count
);

	logic ack_prev;

	// ====================
	// Ack watcher
	// ====================

	// Falling edge sits in the middle of the ack cycle
	always @(negedge clk_sys) begin
		if (reset) begin
			error_count <= 0;
			read_count  <= 0;
			ack_prev    <= 1'b0;
		end else begin
			ack_prev <= wb_ack;

			// The slave acks for a single cycle only
			if (wb_ack && ack_prev) begin
				$display("At %0t the wb_ack signal stayed high for more than one cycle",
					$time);
				error_count <= error_count + 1;
			end

			if (wb_cyc && wb_ack && !wb_we) begin
				read_count <= read_count + 1;
				if (wb_dat_r !== exp_data) begin
					$display("mismatch at %0t: port %0d read %02h, expected %02h",
						$time, wb_adr, wb_dat_r, exp_data);
					error_count <= error_count + 1;
				end
			end
		end
	end

endmodule

//--- tb_mcr3_input.sv
`timescale 1ns/1ps

module tb_mcr3_input;
	import mcr3_game_pkg::*;

	localparam int ACK_TIMEOUT   = 20;
	localparam int RESET_TIMEOUT = 50;

	// One table row with sticks packed p4 to p1 from the top byte down
	typedef struct packed {
		game_t       game;
		logic        onestick;
		logic [31:0] sticks;
		logic [3:0]  coin;
		logic [3:0]  start;
		logic        service;
		logic [3:0]  dip;
		logic [3:0]  pulses;
		logic        do_write;
		logic [2:0]  wr_adr;
		logic [7:0]  wr_dat;
		logic [2:0]  rd_adr;
		logic [7:0]  exp_byte;
	} row_t;

	logic       clk_sys;
	logic       reset;
	game_t      game;
	logic       onestick;
	logic       service;
	logic [3:0] dip;
	logic [3:0] coin;
	logic [3:0] start;
	logic [7:0] p1_stick;
	logic [7:0] p2_stick;
	logic [7:0] p3_stick;
	logic [7:0] p4_stick;
	logic       vsync;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	logic [2:0] wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic       wb_ack;

	logic [7:0] exp_data;
	int         error_count;
	int         read_count;
	int         timeouts;
	int         reads_issued;
	integer     seed;
	row_t       rows [$];

	tb_clock_gen clock_gen_inst (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	mcr3_input_top mcr3_input_top_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.game     (game),
		.onestick (onestick),
		.service  (service),
		.dip      (dip),
		.coin     (coin),
		.start    (start),
		.p1_stick (p1_stick),
		.p2_stick (p2_stick),
		.p3_stick (p3_stick),
		.p4_stick (p4_stick),
		.vsync    (vsync),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	tb_port_checker port_checker_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.wb_cyc      (wb_cyc),
		.wb_we       (wb_we),
		.wb_ack      (wb_ack),
		.wb_adr      (wb_adr),
		.wb_dat_r    (wb_dat_r),
		.exp_data    (exp_data),
		.error_count (error_count),
		.read_count  (read_count)
	);

	// ====================
	// Expected port values
	// ====================

	function automatic logic [7:0] port0_expect(logic svc, logic [3:0] st, logic [3:0] cn);
		return ~{2'b00, svc, 1'b0, st[1:0], cn[1:0]};
	endfunction

	// Two-stick Sarge with fire bits ORed across players 1 and 2
	function automatic logic [7:0] sarge_port1_expect(logic [31:0] sticks);
		logic fa;
		logic fb;
		fa = sticks[4] | sticks[12];
		fb = sticks[5] | sticks[13];
		return ~{fb, fb, fa, fa, sticks[10], sticks[11], sticks[2], sticks[3]};
	endfunction

	// Shifter codes for gears 0 to 4
	function automatic logic [3:0] rpm_code(int gear);
		case (gear)
			1:       return 4'h5;
			2:       return 4'h6;
			3:       return 4'h1;
			4:       return 4'h2;
			default: return 4'h0;
		endcase
	endfunction

	function automatic logic [7:0] rpm_port2_expect(int gear1, int gear2);
		return ~{rpm_code(gear1), rpm_code(gear2)};
	endfunction

	// ====================
	// Bus and pin drivers
	// ====================

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk_sys);
	endtask

	task automatic wait_reset_release(output logic ok);
		int n;
		n = 0;
		while (reset && n < RESET_TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		ok = !reset;
	endtask

	task automatic wb_transfer(input logic we, input logic [2:0] adr, input logic [7:0] dat);
		int waited;
		@(posedge clk_sys);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		waited = 0;
		@(negedge clk_sys);
		while (!wb_ack && waited < ACK_TIMEOUT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!wb_ack) begin
			$display("No ack arrived for the %s of port %0d within %0d cycles",
				we ? "write" : "read", adr, ACK_TIMEOUT);
			timeouts++;
		end
		// Next rising edge is the ack edge
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic pulse_vsync(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			vsync <= 1'b1;
			wait_cycles(4);
			vsync <= 1'b0;
			wait_cycles(4);
		end
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clk_sys);
		game     <= r.game;
		onestick <= r.onestick;
		service  <= r.service;
		dip      <= r.dip;
		coin     <= r.coin;
		start    <= r.start;
		p1_stick <= r.sticks[7:0];
		p2_stick <= r.sticks[15:8];
		p3_stick <= r.sticks[23:16];
		p4_stick <= r.sticks[31:24];
		wait_cycles(8);
		if (r.pulses != 4'd0) begin
			pulse_vsync(int'(r.pulses));
			wait_cycles(8);
		end
		if (r.do_write) begin
			wb_transfer(1'b1, r.wr_adr, r.wr_dat);
			wait_cycles(2);
		end
		exp_data = r.exp_byte;
		reads_issued++;
		wb_transfer(1'b0, r.rd_adr, 8'h00);
	endtask

	// ====================
	// Stimulus table
	// ====================

	task automatic add_row(input game_t g, input logic os, input logic [31:0] sticks,
		input logic [3:0] cn, input logic [3:0] st, input logic [3:0] pulses,
		input logic wr, input logic [2:0] wr_adr, input logic [7:0] wr_dat,
		input logic [2:0] rd_adr, input logic [7:0] exp_byte);
		row_t r;
		r = '{game: g, onestick: os, sticks: sticks, coin: cn, start: st, service: 1'b0,
			dip: 4'h0, pulses: pulses, do_write: wr, wr_adr: wr_adr, wr_dat: wr_dat,
			rd_adr: rd_adr, exp_byte: exp_byte};
		rows.push_back(r);
	endtask

	task automatic build_table();
		row_t        r;
		logic [31:0] rnd;
		int          gear;

		// Output latches after reset then write and read back
		add_row(GAME_SARGE, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd5, 8'h00);
		add_row(GAME_SARGE, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd6, 8'h00);
		add_row(GAME_SARGE, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b1, 3'd5, 8'hA5, 3'd5, 8'hA5);
		add_row(GAME_SARGE, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b1, 3'd6, 8'h3C, 3'd6, 8'h3C);
		add_row(GAME_SARGE, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd7, 8'hFF);
		add_row(GAME_SARGE, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd4, 8'hFF);

		// Power Drive gear toggles from player 1 three times and player 3 once
		for (int k = 1; k <= 3; k++) begin
			add_row(GAME_POWERDRV, 1'b0, 32'h80, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1,
				(k % 2 == 1) ? 8'hFD : 8'hFF);
			add_row(GAME_POWERDRV, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1,
				(k % 2 == 1) ? 8'hFD : 8'hFF);
		end
		add_row(GAME_POWERDRV, 1'b0, 32'h800000, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2, 8'hFD);
		add_row(GAME_POWERDRV, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2, 8'hFD);
		add_row(GAME_POWERDRV, 1'b0, 32'h4000, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1, 8'hED);

		// Max RPM with start1 first so both gearboxes begin in neutral
		add_row(GAME_MAXRPM, 1'b0, 32'h0, 4'h0, 4'h1, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2,
			rpm_port2_expect(0, 0));
		add_row(GAME_MAXRPM, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1, 8'hFF);
		for (int k = 1; k <= 5; k++) begin
			gear = (k > 4) ? 4 : k;
			add_row(GAME_MAXRPM, 1'b0, 32'h10, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2,
				rpm_port2_expect(gear, 0));
			add_row(GAME_MAXRPM, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2,
				rpm_port2_expect(gear, 0));
		end
		add_row(GAME_MAXRPM, 1'b0, 32'h20, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2,
			rpm_port2_expect(3, 0));
		add_row(GAME_MAXRPM, 1'b0, 32'h1000, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2,
			rpm_port2_expect(3, 1));
		add_row(GAME_MAXRPM, 1'b0, 32'h0, 4'h0, 4'h1, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2,
			rpm_port2_expect(0, 1));

		// Demolition Derby wheels 3 and 4 stepped to 5 for the bank select
		add_row(GAME_DDERBY, 1'b0, 32'h01010000, 4'h0, 4'h0, 4'd5, 1'b0, 3'd0, 8'h00, 3'd1,
			8'hFF);
		add_row(GAME_DDERBY, 1'b0, 32'h0, 4'h0, 4'h0, 4'd0, 1'b1, 3'd6, 8'h40, 3'd1, 8'hEB);
		add_row(GAME_DDERBY, 1'b0, 32'h1000, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2, 8'hEA);
		add_row(GAME_DDERBY, 1'b0, 32'h20, 4'h0, 4'h0, 4'd0, 1'b1, 3'd6, 8'h80, 3'd1, 8'hFD);
		// Two left steps wrap wheel1 to 62
		add_row(GAME_DDERBY, 1'b0, 32'h02, 4'h0, 4'h0, 4'd2, 1'b0, 3'd0, 8'h00, 3'd1, 8'h07);
		add_row(GAME_DDERBY, 1'b0, 32'h10000000, 4'h4, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd4, 8'hBE);

		// Sarge one-stick pure directions followed by two-stick
		add_row(GAME_SARGE, 1'b1, 32'h08, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1, 8'hFA);
		add_row(GAME_SARGE, 1'b1, 32'h01, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1, 8'hF6);
		add_row(GAME_SARGE, 1'b1, 32'h04, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1, 8'hF5);
		add_row(GAME_SARGE, 1'b1, 32'h18, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1, 8'hCA);
		add_row(GAME_SARGE, 1'b1, 32'h0800, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2, 8'hFA);
		add_row(GAME_SARGE, 1'b0, 32'h08200000, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd2, 8'h3E);
		add_row(GAME_SARGE, 1'b0, 32'h1008, 4'h0, 4'h0, 4'd0, 1'b0, 3'd0, 8'h00, 3'd1, 8'hCE);

		// Random rows for ports 0, 3 and two-stick Sarge port 1
		for (int i = 0; i < 24; i++) begin
			rnd        = $random(seed);
			r.sticks   = rnd;
			rnd        = $random(seed);
			r.coin     = rnd[3:0];
			r.start    = rnd[7:4];
			r.service  = rnd[8];
			r.dip      = rnd[12:9];
			r.game     = GAME_SARGE;
			r.onestick = 1'b0;
			r.pulses   = 4'd0;
			r.do_write = 1'b0;
			r.wr_adr   = 3'd0;
			r.wr_dat   = 8'h00;
			case (i % 3)
				0: begin
					r.rd_adr   = 3'd0;
					r.exp_byte = port0_expect(r.service, r.start, r.coin);
				end
				1: begin
					r.rd_adr   = 3'd3;
					r.exp_byte = ~{4'h0, r.dip};
				end
				default: begin
					r.rd_adr   = 3'd1;
					r.exp_byte = sarge_port1_expect(r.sticks);
				end
			endcase
			rows.push_back(r);
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		logic reset_ok;
		int   unchecked;

		game         = GAME_SARGE;
		onestick     = 1'b0;
		service      = 1'b0;
		dip          = 4'h0;
		coin         = 4'h0;
		start        = 4'h0;
		p1_stick     = 8'h00;
		p2_stick     = 8'h00;
		p3_stick     = 8'h00;
		p4_stick     = 8'h00;
		vsync        = 1'b0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = 3'd0;
		wb_dat_w     = 8'h00;
		exp_data     = 8'h00;
		timeouts     = 0;
		reads_issued = 0;
		seed         = 87416;

		build_table();
		wait_reset_release(reset_ok);
		if (reset_ok) begin
			for (int i = 0; i < rows.size(); i++)
				apply_row(rows[i]);
		end else begin
			$display("Reset was never released");
			timeouts++;
		end
		wait_cycles(4);

		unchecked = reads_issued - read_count;
		if (unchecked != 0)
			$display("The checker saw %0d read acks but %0d reads were issued",
				read_count, reads_issued);
		$display("Error counts: %0d from the checker, %0d timeouts, %0d unchecked reads",
			error_count, timeouts, unchecked);

		if (error_count == 0 && timeouts == 0 && unchecked == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
mcr3_game_pkg.sv
cabinet_io_pkg.sv
cabinet_ctrl_if.sv
control_decoder.sv
wheel_spinner.sv
io_port_bank.sv
mcr3_input_top.sv
tb_clock_gen.sv
tb_port_checker.sv
tb_mcr3_input.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the testbench and RTL with Verilator, run it and scan the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing \
	-f vlog.f \
	--top-module tb_mcr3_input \
	--Mdir obj_dir \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished, log in sim.log"
exit 0
